// File: verilog/glay_memory_pkg.sv
// Sizes and packed structs shared by the cache front end of the graph engine
// Every module refers to these by package-scoped name

package glay_memory_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------
  // Vertex reader and edge reader
  localparam int num_requestors     = 2;
  localparam int requestor_id_width = 1;
  localparam int addr_width         = 32;
  localparam int data_width         = 64;

  // Cache requests in flight without a response
  localparam int outstanding_max    = 4;

  localparam int fifo_depth         = 8;
  // Almost full once free entries fall below this many
  localparam int almost_full_free   = 4;

  // Derived widths
  localparam int fifo_ptr_width     = $clog2(fifo_depth);
  localparam int fifo_count_width   = $clog2(fifo_depth + 1);
  localparam int credit_width       = $clog2(outstanding_max + 1);

  // --------------------------------------------------------------------------
  // Packets
  // --------------------------------------------------------------------------
  // Read request from one requestor
  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] base_address;
    logic [addr_width-1:0] address_offset;
  } memory_request_t;

  // Read request toward the cache, tagged with its requestor
  typedef struct packed {
    logic                          valid;
    logic [requestor_id_width-1:0] id;
    logic [addr_width-1:0]         addr;
  } cache_request_t;

  // Cache answer carrying the id of the request
  typedef struct packed {
    logic                          valid;
    logic [requestor_id_width-1:0] id;
    logic [data_width-1:0]         data;
  } cache_response_t;

  // Answer as seen by the owning requestor
  typedef struct packed {
    logic                  valid;
    logic [data_width-1:0] data;
  } requestor_response_t;

endpackage

// File: verilog/request_arbiter.sv
// Round-robin arbiter between the two registered requestor inputs
// One loser parks in a hold register and goes out on the next cycle
`timescale 1ns/1ps

module request_arbiter (
  input  logic                                   ap_clk,
  input  logic                                   control_areset,
  input  glay_memory_pkg::memory_request_t       req_in [glay_memory_pkg::num_requestors],
  output glay_memory_pkg::cache_request_t        grant_out,
  output logic [glay_memory_pkg::addr_width-1:0] grant_offset
);

  // --------------------------------------------------------------------------
  // Hold register and priority state
  // --------------------------------------------------------------------------
  glay_memory_pkg::memory_request_t               hold_req;
  logic [glay_memory_pkg::requestor_id_width-1:0] hold_id;
  logic                                           hold_valid;
  // Id granted most recently
  logic [glay_memory_pkg::requestor_id_width-1:0] last_id;
  // Favoured requestor on a tie
  logic [glay_memory_pkg::requestor_id_width-1:0] prio_id;
  logic                                           both_valid;

  // Next grant and next hold contents
  logic                                           grant_valid;
  logic [glay_memory_pkg::requestor_id_width-1:0] grant_id;
  glay_memory_pkg::memory_request_t               grant_req;
  logic                                           hold_load;
  logic [glay_memory_pkg::requestor_id_width-1:0] hold_load_id;

  assign both_valid = req_in[0].valid & req_in[1].valid;
  assign prio_id    = ~last_id;

  // --------------------------------------------------------------------------
  // Grant selection
  // --------------------------------------------------------------------------
  always_comb begin
    grant_valid  = 1'b1;
    grant_id     = '0;
    grant_req    = req_in[0];
    hold_load    = 1'b0;
    hold_load_id = '0;
    if (hold_valid) begin
      // Parked loser first, keeps per-requestor order
      grant_id  = hold_id;
      grant_req = hold_req;
      if (req_in[0].valid | req_in[1].valid) begin
        hold_load    = 1'b1;
        hold_load_id = req_in[1].valid;
      end
    end else if (both_valid) begin
      // Tie goes to the one not served last
      grant_id     = prio_id;
      grant_req    = req_in[prio_id];
      hold_load    = 1'b1;
      hold_load_id = ~prio_id;
    end else if (req_in[0].valid) begin
      grant_id  = 1'b0;
      grant_req = req_in[0];
    end else if (req_in[1].valid) begin
      grant_id  = 1'b1;
      grant_req = req_in[1];
    end else begin
      grant_valid = 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      hold_valid      <= 1'b0;
      // Priority starts at requestor 0
      last_id         <= '1;
      grant_out.valid <= 1'b0;
    end else begin
      hold_valid      <= hold_load;
      grant_out.valid <= grant_valid;
      if (grant_valid) begin
        last_id <= grant_id;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (hold_load) begin
      hold_req <= req_in[hold_load_id];
      hold_id  <= hold_load_id;
    end
    // addr carries the base until the adder stage
    grant_out.id   <= grant_id;
    grant_out.addr <= grant_req.base_address;
    grant_offset   <= grant_req.address_offset;
  end

  // Generator keeps a pair out while a loser is parked
  hold_no_overflow_a : assert property (
    @(posedge ap_clk) disable iff (control_areset)
    hold_valid |-> !both_valid
  );

endmodule

// File: verilog/request_fifo.sv
// Synchronous FIFO of tagged cache requests between address stage and cache
// dout is registered and valid one cycle after rd_en
`timescale 1ns/1ps

module request_fifo (
  input  logic                            ap_clk,
  input  logic                            control_areset,
  input  glay_memory_pkg::cache_request_t din,
  input  logic                            wr_en,
  input  logic                            rd_en,
  output glay_memory_pkg::cache_request_t dout,
  output logic                            full,
  output logic                            empty,
  output logic                            almost_full
);

  // --------------------------------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------------------------------
  glay_memory_pkg::cache_request_t              mem [glay_memory_pkg::fifo_depth];
  logic [glay_memory_pkg::fifo_ptr_width-1:0]   wr_ptr;
  logic [glay_memory_pkg::fifo_ptr_width-1:0]   rd_ptr;
  // Entries currently stored
  logic [glay_memory_pkg::fifo_count_width-1:0] count;

  // Status flags
  assign full  = count == glay_memory_pkg::fifo_count_width'(glay_memory_pkg::fifo_depth);
  assign empty = count == '0;
  // Free space below the margin
  assign almost_full =
    (glay_memory_pkg::fifo_count_width'(glay_memory_pkg::fifo_depth) - count) <
    glay_memory_pkg::fifo_count_width'(glay_memory_pkg::almost_full_free);

  // --------------------------------------------------------------------------
  // Control
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      dout.valid <= 1'b0;
    end else begin
      // Pointers wrap on their own, depth is a power of two
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      dout.valid <= rd_en;
    end
  end

  // --------------------------------------------------------------------------
  // Data path
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
    if (rd_en) begin
      dout.id   <= mem[rd_ptr].id;
      dout.addr <= mem[rd_ptr].addr;
    end
  end

  // Upstream margin must keep writes out of a full FIFO
  no_write_when_full_a : assert property (
    @(posedge ap_clk) disable iff (control_areset)
    !(wr_en && full)
  );

  no_read_when_empty_a : assert property (
    @(posedge ap_clk) disable iff (control_areset)
    !(rd_en && empty)
  );

endmodule

// File: verilog/outstanding_credit_counter.sv
// Credit pool for cache requests in flight without a response
// take on issue, give on a returned response
`timescale 1ns/1ps

module outstanding_credit_counter (
  input  logic ap_clk,
  input  logic control_areset,
  input  logic take,
  input  logic give,
  output logic has_credit
);

  // Free credits
  logic [glay_memory_pkg::credit_width-1:0] count;

  // --------------------------------------------------------------------------
  // Count update
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      // Full pool after reset
      count <= glay_memory_pkg::credit_width'(glay_memory_pkg::outstanding_max);
    end else if (take && !give) begin
      count <= count - 1'b1;
    end else if (give && !take) begin
      count <= count + 1'b1;
    end
    // take and give together cancel
  end

  assign has_credit = count != '0;

  // Issue is gated by has_credit
  no_take_at_zero_a : assert property (
    @(posedge ap_clk) disable iff (control_areset)
    take |-> count != '0
  );

  // Cache must answer each request once only
  count_in_range_a : assert property (
    @(posedge ap_clk) disable iff (control_areset)
    count <= glay_memory_pkg::credit_width'(glay_memory_pkg::outstanding_max)
  );

endmodule

// File: verilog/cache_request_generator.sv
// Turns two requestor read streams into one credit-gated cache request stream
// Input register, arbiter, adder stage, FIFO, then out to the cache
`timescale 1ns/1ps

module cache_request_generator (
  input  logic                                       ap_clk,
  input  logic                                       control_areset,
  input  glay_memory_pkg::memory_request_t           mem_req [glay_memory_pkg::num_requestors],
  output logic [glay_memory_pkg::num_requestors-1:0] request_ready,
  input  logic                                       resp_seen,
  output glay_memory_pkg::cache_request_t            cache_req
);

  // --------------------------------------------------------------------------
  // Stage signals
  // --------------------------------------------------------------------------
  glay_memory_pkg::memory_request_t       mem_req_reg [glay_memory_pkg::num_requestors];
  // Both inputs registered in one cycle
  logic                                   in_pair_pending;

  // Arbiter output, addr still holds the base
  glay_memory_pkg::cache_request_t        arb_grant;
  logic [glay_memory_pkg::addr_width-1:0] arb_offset;

  // FIFO side
  glay_memory_pkg::cache_request_t        fifo_din;
  logic                                   fifo_rd_en;
  logic                                   fifo_empty;
  logic                                   fifo_almost_full;

  // Credits
  logic                                   has_credit;
  logic                                   resp_seen_reg;

  // --------------------------------------------------------------------------
  // Input register
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      for (int i = 0; i < glay_memory_pkg::num_requestors; i++) begin
        mem_req_reg[i].valid <= 1'b0;
      end
      resp_seen_reg <= 1'b0;
    end else begin
      for (int i = 0; i < glay_memory_pkg::num_requestors; i++) begin
        mem_req_reg[i].valid <= mem_req[i].valid;
      end
      // Credit comes back one cycle after the response
      resp_seen_reg <= resp_seen;
    end
    for (int i = 0; i < glay_memory_pkg::num_requestors; i++) begin
      mem_req_reg[i].base_address   <= mem_req[i].base_address;
      mem_req_reg[i].address_offset <= mem_req[i].address_offset;
    end
  end

  // A registered pair parks one request in the arbiter hold register
  // Skipping one cycle lets it drain before the next pair
  assign in_pair_pending = mem_req_reg[0].valid & mem_req_reg[1].valid;
  assign request_ready   =
    {glay_memory_pkg::num_requestors{~(fifo_almost_full | in_pair_pending)}};

  // --------------------------------------------------------------------------
  // Arbitration
  // --------------------------------------------------------------------------
  request_arbiter arbiter_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .req_in         (mem_req_reg),
    .grant_out      (arb_grant),
    .grant_offset   (arb_offset)
  );

  // --------------------------------------------------------------------------
  // Address stage
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      fifo_din.valid <= 1'b0;
    end else begin
      fifo_din.valid <= arb_grant.valid;
    end
    // Byte address is base plus offset
    fifo_din.id   <= arb_grant.id;
    fifo_din.addr <= arb_grant.addr + arb_offset;
  end

  // --------------------------------------------------------------------------
  // Request queue, registered dout goes straight to the cache
  // --------------------------------------------------------------------------
  // Issue only with a credit in hand
  assign fifo_rd_en = ~fifo_empty & has_credit;

  request_fifo fifo_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .din            (fifo_din),
    .wr_en          (fifo_din.valid),
    .rd_en          (fifo_rd_en),
    .dout           (cache_req),
    .full           (),
    .empty          (fifo_empty),
    .almost_full    (fifo_almost_full)
  );

  // --------------------------------------------------------------------------
  // Outstanding transactions
  // --------------------------------------------------------------------------
  outstanding_credit_counter credit_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .take           (fifo_rd_en),
    .give           (resp_seen_reg),
    .has_credit     (has_credit)
  );

endmodule

// File: verilog/cache_response_router.sv
// Steers each cache response to the requestor named by its id
// One register stage, and the raw valid is handed back as a credit
`timescale 1ns/1ps

module cache_response_router (
  input  logic                                 ap_clk,
  input  logic                                 control_areset,
  input  glay_memory_pkg::cache_response_t     cache_resp,
  output glay_memory_pkg::requestor_response_t req_resp [glay_memory_pkg::num_requestors],
  output logic                                 resp_seen
);

  // --------------------------------------------------------------------------
  // Response register
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      for (int i = 0; i < glay_memory_pkg::num_requestors; i++) begin
        req_resp[i].valid <= 1'b0;
      end
    end else begin
      // Valid only on the owning entry
      for (int i = 0; i < glay_memory_pkg::num_requestors; i++) begin
        req_resp[i].valid <= cache_resp.valid &&
          (cache_resp.id == glay_memory_pkg::requestor_id_width'(i));
      end
    end
    // Data fans out to every entry
    for (int i = 0; i < glay_memory_pkg::num_requestors; i++) begin
      req_resp[i].data <= cache_resp.data;
    end
  end

  // Credit return to the generator
  assign resp_seen = cache_resp.valid;

endmodule

// File: verilog/glay_cache_port.sv
// Cache front end of the graph engine, two read requestors to one cache port
// Requests go out through the generator, responses come back through the router
`timescale 1ns/1ps

module glay_cache_port (
  input  logic                                       ap_clk,
  input  logic                                       control_areset,
  input  glay_memory_pkg::memory_request_t           mem_req [glay_memory_pkg::num_requestors],
  output logic [glay_memory_pkg::num_requestors-1:0] request_ready,
  output glay_memory_pkg::cache_request_t            cache_req,
  input  glay_memory_pkg::cache_response_t           cache_resp,
  output glay_memory_pkg::requestor_response_t       req_resp [glay_memory_pkg::num_requestors]
);

  // Response pulse that frees one credit
  logic resp_seen;

  // --------------------------------------------------------------------------
  // Request path
  // --------------------------------------------------------------------------
  cache_request_generator generator_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .mem_req        (mem_req),
    .request_ready  (request_ready),
    .resp_seen      (resp_seen),
    .cache_req      (cache_req)
  );

  // --------------------------------------------------------------------------
  // Response path
  // --------------------------------------------------------------------------
  cache_response_router router_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .cache_resp     (cache_resp),
    .req_resp       (req_resp),
    .resp_seen      (resp_seen)
  );

endmodule

// File: verif/glay_cache_port_tb.sv
// Testbench for the cache front end, stimulus from verif/cache_port_tests.txt
// A cache model answers in random order while scoreboards check both paths
`timescale 1ns/1ps

module glay_cache_port_tb;

  localparam int max_tests = 64;
  // Cache answer is the address scrambled with this word
  localparam logic [63:0] data_pattern = 64'ha5a5_0f0f_c3c3_3c3c;

  logic ap_clk = 1'b0;
  logic control_areset;
  glay_memory_pkg::memory_request_t           mem_req [glay_memory_pkg::num_requestors];
  logic [glay_memory_pkg::num_requestors-1:0] request_ready;
  glay_memory_pkg::cache_request_t            cache_req;
  glay_memory_pkg::cache_response_t           cache_resp;
  glay_memory_pkg::requestor_response_t       req_resp [glay_memory_pkg::num_requestors];

  // kind, id, base, offset, expected address
  logic [103:0] tests [max_tests];
  // {paired, id, addr} for requests not yet seen at the cache
  logic [33:0]  exp_q [$];
  // {due cycle, id, addr} for requests the cache still owes
  logic [64:0]  pend_q [$];
  glay_memory_pkg::cache_response_t prev_resp;
  int sent [2];
  int issued [2];
  int outstanding;
  // Requestor served most recently at the cache
  logic last_grant;
  int hold_left;
  int cycle_count;
  int cycle_limit;
  int checks;
  int errors;
  logic [31:0] rng_state;

  glay_cache_port dut_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .mem_req        (mem_req),
    .request_ready  (request_ready),
    .cache_req      (cache_req),
    .cache_resp     (cache_resp),
    .req_resp       (req_resp)
  );

  always #20 ap_clk = ~ap_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic finish_run;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  // --------------------------------------------------------------------------
  // Requestor side
  // --------------------------------------------------------------------------
  task automatic send_requests(input logic [103:0] first, input logic [103:0] second,
                               input logic paired);
    glay_memory_pkg::memory_request_t req [2];
    logic [1:0] need;
    req[0] = '0;
    req[1] = '0;
    req[first[96]] = {1'b1, first[95:64], first[63:32]};
    need = 2'b01 << first[96];
    if (paired) begin
      req[second[96]] = {1'b1, second[95:64], second[63:32]};
      need = need | (2'b01 << second[96]);
    end
    // Wait for every requestor involved
    @(posedge ap_clk);
    while ((request_ready & need) != need) @(posedge ap_clk);
    mem_req[0] <= req[0];
    mem_req[1] <= req[1];
    @(negedge ap_clk);
    exp_q.push_back({paired, first[96], first[31:0]});
    sent[first[96]]++;
    if (paired) begin
      exp_q.push_back({paired, second[96], second[31:0]});
      sent[second[96]]++;
    end
    // One idle cycle, ready drops after a registered pair
    @(posedge ap_clk);
    mem_req[0].valid <= 1'b0;
    mem_req[1].valid <= 1'b0;
  endtask

  task automatic drain;
    @(negedge ap_clk);
    while (exp_q.size() != 0 || pend_q.size() != 0 || hold_left != 0) @(negedge ap_clk);
    // Last answer still crossing the router
    repeat (3) @(negedge ap_clk);
  endtask

  // --------------------------------------------------------------------------
  // Cache model and request scoreboard
  // --------------------------------------------------------------------------
  always @(posedge ap_clk) begin
    int idx;
    int pick;
    logic [31:0] due;
    logic partner;
    if (control_areset) begin
      cache_resp <= '0;
      // Priority points at requestor 0 after reset
      last_grant = 1'b1;
    end else begin
      cycle_count++;
      cache_resp <= '0;
      if (cache_req.valid) begin
        checks += 2;
        assert (outstanding < glay_memory_pkg::outstanding_max) else begin
          errors++;
          $display("Time %0t: cache request issued with every credit in use", $time);
        end
        // Oldest request still waiting from the same requestor
        idx = -1;
        for (int k = 0; k < exp_q.size(); k++) begin
          if (idx < 0 && exp_q[k][32] == cache_req.id) idx = k;
        end
        assert (idx >= 0) else begin
          errors++;
          $display("Time %0t: requestor %0d got a cache request it never sent",
                   $time, cache_req.id);
        end
        if (idx >= 0) begin
          checks++;
          assert (cache_req.addr == exp_q[idx][31:0]) else begin
            errors++;
            $display("CHECK FAILED at %0t: cache_req.addr expected %h actual %h",
                     $time, exp_q[idx][31:0], cache_req.addr);
          end
          // First grant of a pair goes to the requestor not served last
          if (exp_q[idx][33]) begin
            partner = 1'b0;
            for (int k = 0; k < exp_q.size(); k++) begin
              if (exp_q[k][32] != cache_req.id && exp_q[k][33]) partner = 1'b1;
            end
            if (partner) begin
              checks++;
              assert (cache_req.id == ~last_grant) else begin
                errors++;
                $display("CHECK FAILED at %0t: cache_req.id expected %0d actual %0d",
                         $time, ~last_grant, cache_req.id);
              end
            end
          end
          exp_q.delete(idx);
        end
        last_grant = cache_req.id;
        issued[cache_req.id]++;
        outstanding++;
        rng_state = xorshift(rng_state);
        due = cycle_count + (rng_state % 8);
        pend_q.push_back({due, cache_req.id, cache_req.addr});
      end
      if (hold_left > 0) begin
        hold_left--;
        if (hold_left == 0) begin
          checks++;
          assert (outstanding == glay_memory_pkg::outstanding_max) else begin
            errors++;
            $display("Time %0t: hold window ended with %0d requests in flight, not all credits",
                     $time, outstanding);
          end
        end
      end else if (pend_q.size() > 0) begin
        // Random pick gives out-of-order answers
        rng_state = xorshift(rng_state);
        pick = rng_state % pend_q.size();
        if (pend_q[pick][64:33] <= cycle_count) begin
          cache_resp <= {1'b1, pend_q[pick][32], {32'h0, pend_q[pick][31:0]} ^ data_pattern};
          outstanding--;
          pend_q.delete(pick);
        end
      end
    end
  end

  // Router, one cycle from cache_resp, also covers idle entries after reset
  always @(posedge ap_clk) begin
    logic exp_valid;
    if (!control_areset) begin
      for (int i = 0; i < glay_memory_pkg::num_requestors; i++) begin
        exp_valid = prev_resp.valid && prev_resp.id == i;
        checks++;
        assert (req_resp[i].valid == exp_valid) else begin
          errors++;
          $display("CHECK FAILED at %0t: req_resp[%0d].valid expected %b actual %b",
                   $time, i, exp_valid, req_resp[i].valid);
        end
        if (exp_valid) begin
          checks++;
          assert (req_resp[i].data == prev_resp.data) else begin
            errors++;
            $display("CHECK FAILED at %0t: req_resp[%0d].data expected %h actual %h",
                     $time, i, prev_resp.data, req_resp[i].data);
          end
        end
      end
    end
    prev_resp = cache_resp;
  end

  // --------------------------------------------------------------------------
  // Sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    int n;
    int hold_total;
    int i;
    control_areset = 1'b1;
    cache_resp = '0;
    mem_req[0] = '0;
    mem_req[1] = '0;
    rng_state = 32'h1977;
    $readmemh("verif/cache_port_tests.txt", tests);
    n = 0;
    hold_total = 0;
    while (n < max_tests && tests[n][103:100] !== 4'hf) begin
      if (tests[n][103:100] == 4'h2) hold_total += tests[n][95:64];
      n++;
    end
    cycle_limit = n * 20 + hold_total + 200;
    repeat (8) @(posedge ap_clk);
    control_areset <= 1'b0;
    @(negedge ap_clk);
    checks += 2;
    assert (cache_req.valid == 1'b0) else begin
      errors++;
      $display("CHECK FAILED at %0t: cache_req.valid expected 0 actual %b", $time, cache_req.valid);
    end
    assert (request_ready == 2'b11) else begin
      errors++;
      $display("CHECK FAILED at %0t: request_ready expected 11 actual %b", $time, request_ready);
    end
    i = 0;
    while (i < n) begin
      case (tests[i][103:100])
        4'h0: send_requests(tests[i], tests[i], 1'b0);
        4'h1: begin
          send_requests(tests[i], tests[i + 1], 1'b1);
          i++;
        end
        4'h2: begin
          @(negedge ap_clk);
          hold_left = tests[i][95:64];
        end
        default: drain();
      endcase
      i++;
    end
    drain();
    for (int k = 0; k < glay_memory_pkg::num_requestors; k++) begin
      checks++;
      assert (issued[k] == sent[k]) else begin
        errors++;
        $display("Requestor %0d sent %0d requests but %0d reached the cache", k, sent[k], issued[k]);
      end
    end
    finish_run();
  end

  initial begin
    wait (cycle_limit != 0);
    repeat (cycle_limit) @(posedge ap_clk);
    errors++;
    $display("Timeout: tests did not complete within %0d cycles", cycle_limit);
    finish_run();
  end

endmodule

// File: compile.f
verilog/glay_memory_pkg.sv
verilog/request_arbiter.sv
verilog/request_fifo.sv
verilog/outstanding_credit_counter.sv
verilog/cache_request_generator.sv
verilog/cache_response_router.sv
verilog/glay_cache_port.sv
verif/glay_cache_port_tb.sv

// File: verif/cache_port_tests.txt
// Columns: kind _ requestor _ base _ offset _ expected address (base + offset)
// kind 0 one request, 1 paired with next line, 2 hold answers base cycles, 3 drain, f end
// Requestor 0 alone
0_0_00001000_00000010_00001010
0_0_00001000_00000018_00001018
0_0_00020000_00000100_00020100
// Requestor 1 alone
0_1_80000000_00000040_80000040
0_1_80000000_00001fc0_80001fc0
// Alternating, second one wraps the address space
0_0_0000fff0_00000020_00010010
0_1_ffffff00_00000200_00000100
3_0_00000000_00000000_00000000
// Both requestors in the same cycle
1_0_10000000_00000000_10000000
0_1_20000000_00000008_20000008
1_0_10000000_00000008_10000008
0_1_20000000_00000010_20000010
1_0_10000000_00000010_10000010
0_1_20000000_00000018_20000018
1_0_10000000_00000018_10000018
0_1_20000000_00000020_20000020
3_0_00000000_00000000_00000000
// Cache silent for 40 cycles, credits run out
2_0_00000028_00000000_00000000
0_0_30000000_00000004_30000004
0_1_40000000_00000004_40000004
0_0_30000000_0000000c_3000000c
0_1_40000000_0000000c_4000000c
0_0_30000000_00000014_30000014
0_1_40000000_00000014_40000014
3_0_00000000_00000000_00000000
f_0_00000000_00000000_00000000
